/* am_lock_pkg.sv */
package am_lock_pkg;

	localparam int NB_DATA_CODED = 66;
	localparam int NB_AM = 48; // M0-M2 and M4-M6
	localparam int N_ALIGNER = 20;
	localparam int NB_LANE_ID = 5;
	localparam int NB_BIP = 8;

	localparam logic [1:0] CTRL_SH = 2'b10;
	localparam logic [7:0] BLOCK_TYPE_CTRL = 8'h1E;
	localparam logic [6:0] PCS_IDLE = 7'h00;

	// sync header on top, then M0 M1 M2, BIP3 right below them
	localparam int BIP_MSB_POS = NB_DATA_CODED - 2 - 24 - 1;

	localparam logic [NB_DATA_CODED-1:0] IDLE_BLOCK = {CTRL_SH, BLOCK_TYPE_CTRL, {8{PCS_IDLE}}};

	// per lane {M0, M1, M2, M4, M5, M6}, M0 in the top byte
	localparam logic [NB_AM-1:0] AM_TABLE [N_ALIGNER] = '{
		48'hC16821_3E97DE, 48'h9D718E_628E71, 48'h594BE8_A6B417, 48'h4D957B_B26A84,
		48'hF50709_0AF8F6, 48'hDD14C2_22EB3D, 48'h9A4A26_65B5D9, 48'h7B4566_84BA99,
		48'hA02476_5FDB89, 48'h68C9FB_973604, 48'hFD6C99_029366, 48'hB99155_466EAA,
		48'h5CB9B2_A3464D, 48'h1AF8BD_E50742, 48'h83C7CA_7C3835, 48'h3536CD_CAC932,
		48'hC4314C_3BCEB3, 48'hADD6B7_522948, 48'h5F662A_A099D5, 48'hC0F0E5_3F0F1A
	};

endpackage

/* am_lock_comparator.sv */
module am_lock_comparator
(
	input  logic [am_lock_pkg::NB_AM-1:0] i_am_value,
	input  logic [am_lock_pkg::NB_AM-1:0] i_compare_mask, // 1 = bit is compared
	input  logic [am_lock_pkg::N_ALIGNER-1:0] i_match_mask, // locked lane, one-hot
	input  logic i_enable_mask,

	output logic o_am_match,
	output logic [am_lock_pkg::N_ALIGNER-1:0] o_match_vector
);

	import am_lock_pkg::*;

	logic [N_ALIGNER-1:0] raw_match;
	logic [N_ALIGNER-1:0] accepted_match;

	// masked compare against every lane marker
	always_comb
	begin
		for (int lane = 0; lane < N_ALIGNER; lane++)
		begin
			raw_match[lane] = ((i_am_value ^ AM_TABLE[lane]) & i_compare_mask) == '0;
		end
	end

	// once a lane is latched only its own marker is accepted
	always_comb
	begin
		if (i_enable_mask)
		begin
			accepted_match = raw_match & i_match_mask;
		end
		else
		begin
			accepted_match = raw_match;
		end
	end

	assign o_match_vector = accepted_match;
	assign o_am_match = |accepted_match;

endmodule

/* am_lock_fsm.sv */
module am_lock_fsm
#(
	parameter N_BLOCKS = 16383,
	parameter NB_INV_AM = 3,
	parameter NB_VAL_AM = 5
)
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_enable,
	input  logic i_valid,
	input  logic i_block_lock,
	input  logic i_am_valid, // accepted match from comparator
	input  logic [am_lock_pkg::N_ALIGNER-1:0] i_match_vector,
	input  logic [NB_VAL_AM-1:0] i_lock_thr,
	input  logic [NB_INV_AM-1:0] i_unlock_thr,

	output logic [am_lock_pkg::N_ALIGNER-1:0] o_match_mask,
	output logic o_enable_mask,
	output logic o_am_lock,
	output logic o_resync_by_am_start,
	output logic o_start_of_lane
);

	import am_lock_pkg::*;

	localparam int NB_PERIOD = $clog2(N_BLOCKS + 1);
	localparam logic [NB_PERIOD-1:0] LAST_BLOCK = NB_PERIOD'(N_BLOCKS - 1);

	typedef enum logic [1:0]
	{
		ST_SEARCH,
		ST_COUNT,
		ST_CHECK
	} state_t;

	state_t state;
	logic [NB_PERIOD-1:0] block_count; // valid blocks since last marker
	logic [NB_VAL_AM-1:0] valid_count;
	logic [NB_INV_AM-1:0] invalid_count;
	logic [N_ALIGNER-1:0] first_lane;
	logic advance;
	logic lock_reached;
	logic unlock_reached;
	logic drop;

	assign advance = i_enable & i_valid;

	// lowest matching lane if the mask lets several through
	assign first_lane = i_match_vector & (~i_match_vector + 1'b1);

	assign lock_reached = ({1'b0, valid_count} + 1'b1) >= {1'b0, i_lock_thr};
	assign unlock_reached = ({1'b0, invalid_count} + 1'b1) >= {1'b0, i_unlock_thr};

	// back to search, from any state but search itself
	always_comb
	begin
		drop = 1'b0;
		if (state != ST_SEARCH)
		begin
			if (!i_block_lock)
			begin
				drop = 1'b1;
			end
			else if (state == ST_CHECK && !i_am_valid && (!o_am_lock || unlock_reached))
			begin
				drop = 1'b1; // one miss before lock, thr misses after
			end
		end
	end

	assign o_resync_by_am_start = advance & drop;
	assign o_start_of_lane = advance & (state == ST_CHECK);
	assign o_enable_mask = (state != ST_SEARCH);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state <= ST_SEARCH;
			block_count <= '0;
			valid_count <= '0;
			invalid_count <= '0;
			o_match_mask <= '0;
			o_am_lock <= 1'b0;
		end
		else if (advance)
		begin
			if (drop)
			begin
				state <= ST_SEARCH;
				block_count <= '0;
				valid_count <= '0;
				invalid_count <= '0;
				o_match_mask <= '0;
				o_am_lock <= 1'b0;
			end
			else
			begin
				case (state)
					ST_SEARCH:
					begin
						if (i_am_valid && i_block_lock)
						begin
							o_match_mask <= first_lane;
							valid_count <= NB_VAL_AM'(1); // first sighting counts
							invalid_count <= '0;
							block_count <= '0;
							state <= ST_COUNT;
							if (lock_reached)
							begin
								o_am_lock <= 1'b1;
							end
						end
					end
					ST_COUNT:
					begin
						if (block_count == LAST_BLOCK)
						begin
							state <= ST_CHECK; // next valid block is the marker
						end
						else
						begin
							block_count <= block_count + 1'b1;
						end
					end
					ST_CHECK:
					begin
						block_count <= '0;
						state <= ST_COUNT;
						if (i_am_valid)
						begin
							invalid_count <= '0;
							if (valid_count < i_lock_thr)
							begin
								valid_count <= valid_count + 1'b1;
							end
							if (lock_reached)
							begin
								o_am_lock <= 1'b1;
							end
						end
						else
						begin
							valid_count <= '0;
							invalid_count <= invalid_count + 1'b1; // locked, below thr
						end
					end
					default:
					begin
						state <= ST_SEARCH;
					end
				endcase
			end
		end
	end

endmodule

/* bip_calculator.sv */
module bip_calculator
#(
	parameter NB_DATA_CODED = 66
)
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_enable,
	input  logic i_valid,
	input  logic [NB_DATA_CODED-1:0] i_data,
	input  logic i_start_of_lane, // marker block, resync or first sighting

	output logic [am_lock_pkg::NB_BIP-1:0] o_bip3
);

	import am_lock_pkg::*;

	logic [NB_BIP-1:0] block_bip;
	logic [NB_BIP-1:0] bip_acc;

	// bit j in transmit order sits at i_data[NB_DATA_CODED-1-j]
	always_comb
	begin
		block_bip = '0;
		for (int j = 2; j < NB_DATA_CODED; j++)
		begin
			block_bip[(j - 2) % NB_BIP] = block_bip[(j - 2) % NB_BIP] ^ i_data[NB_DATA_CODED - 1 - j];
		end
		block_bip[3] = block_bip[3] ^ i_data[NB_DATA_CODED - 1]; // sync bit 0
		block_bip[4] = block_bip[4] ^ i_data[NB_DATA_CODED - 2]; // sync bit 1
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			bip_acc <= '0;
		end
		else if (i_enable && i_valid)
		begin
			if (i_start_of_lane)
			begin
				bip_acc <= block_bip; // new period starts with this block
			end
			else
			begin
				bip_acc <= bip_acc ^ block_bip;
			end
		end
	end

	// finished period value while the marker block is on the input
	assign o_bip3 = bip_acc;

endmodule

/* am_error_counter.sv */
module am_error_counter
#(
	parameter NB_BIP = 8,
	parameter NB_COUNTER = 32
)
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_enable,
	input  logic i_match, // good marker at expected position
	input  logic i_reset_count,
	input  logic [NB_BIP-1:0] i_recived_bip,
	input  logic [NB_BIP-1:0] i_calculated_bip,

	output logic [NB_COUNTER-1:0] o_rf_error_count
);

	logic bip_error;
	logic saturated;

	assign bip_error = i_recived_bip != i_calculated_bip;
	assign saturated = &o_rf_error_count;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_rf_error_count <= '0;
		end
		else if (i_enable)
		begin
			if (i_reset_count)
			begin
				o_rf_error_count <= '0;
			end
			else if (i_match && bip_error && !saturated)
			begin
				o_rf_error_count <= o_rf_error_count + 1'b1; // holds at all ones
			end
		end
	end

endmodule

/* am_lock_module.sv */
module am_lock_module
#(
	parameter N_BLOCKS = 16383,
	parameter NB_ERROR_COUNTER = 32,
	parameter NB_INV_AM = 3,
	parameter NB_VAL_AM = 5
)
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_rf_enable,
	input  logic i_valid, // block strobe
	input  logic i_block_lock, // from block sync
	input  logic [am_lock_pkg::NB_DATA_CODED-1:0] i_data,
	input  logic [NB_INV_AM-1:0] i_rf_invalid_am_thr,
	input  logic [NB_VAL_AM-1:0] i_rf_valid_am_thr,
	input  logic [am_lock_pkg::NB_AM-1:0] i_rf_compare_mask,

	output logic [am_lock_pkg::NB_DATA_CODED-1:0] o_data, // to deskew
	output logic [am_lock_pkg::NB_LANE_ID-1:0] o_lane_id, // to lane reorder
	output logic [NB_ERROR_COUNTER-1:0] o_rf_error_counter,
	output logic o_am_lock,
	output logic o_resync,
	output logic o_start_of_lane
);

	import am_lock_pkg::*;

	logic [NB_AM-1:0] am_value;
	logic [NB_BIP-1:0] recived_bip;
	logic [NB_BIP-1:0] calculated_bip;
	logic [N_ALIGNER-1:0] match_mask;
	logic [N_ALIGNER-1:0] match_vector;
	logic [NB_LANE_ID-1:0] lane_index;
	logic am_match;
	logic enable_mask;
	logic start_of_lane;
	logic resync;
	logic am_lock;
	logic bip_restart;

	// M0-M2 above the BIP3 byte, M4-M6 below it
	assign am_value = {i_data[NB_DATA_CODED-3 -: NB_AM/2], i_data[BIP_MSB_POS-NB_BIP -: NB_AM/2]};
	assign recived_bip = i_data[BIP_MSB_POS -: NB_BIP];

	// search-state match is a first sighting, parity starts there too
	assign bip_restart = start_of_lane | resync | (am_match & ~enable_mask);

	always_comb
	begin
		lane_index = '0;
		for (int lane = 0; lane < N_ALIGNER; lane++)
		begin
			if (match_mask[lane])
			begin
				lane_index = NB_LANE_ID'(lane);
			end
		end
	end

	assign o_lane_id = am_lock ? lane_index : '0;
	assign o_data = (start_of_lane && am_lock) ? IDLE_BLOCK : i_data; // marker out, idle in
	assign o_am_lock = am_lock;
	assign o_resync = resync;
	assign o_start_of_lane = start_of_lane;

	am_lock_comparator u_am_lock_comparator
	(
		.i_am_value (am_value),
		.i_compare_mask (i_rf_compare_mask),
		.i_match_mask (match_mask),
		.i_enable_mask (enable_mask),
		.o_am_match (am_match),
		.o_match_vector (match_vector)
	);

	am_lock_fsm
	#(
		.N_BLOCKS (N_BLOCKS),
		.NB_INV_AM (NB_INV_AM),
		.NB_VAL_AM (NB_VAL_AM)
	)
	u_am_lock_fsm
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_enable (i_rf_enable),
		.i_valid (i_valid),
		.i_block_lock (i_block_lock),
		.i_am_valid (am_match),
		.i_match_vector (match_vector),
		.i_lock_thr (i_rf_valid_am_thr),
		.i_unlock_thr (i_rf_invalid_am_thr),
		.o_match_mask (match_mask),
		.o_enable_mask (enable_mask),
		.o_am_lock (am_lock),
		.o_resync_by_am_start (resync),
		.o_start_of_lane (start_of_lane)
	);

	bip_calculator
	#(
		.NB_DATA_CODED (NB_DATA_CODED)
	)
	u_bip_calculator
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_enable (i_rf_enable),
		.i_valid (i_valid),
		.i_data (i_data),
		.i_start_of_lane (bip_restart),
		.o_bip3 (calculated_bip)
	);

	am_error_counter
	#(
		.NB_BIP (NB_BIP),
		.NB_COUNTER (NB_ERROR_COUNTER)
	)
	u_am_error_counter
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_enable (i_rf_enable),
		.i_match (start_of_lane & am_match), // a missing marker has no BIP3 byte
		.i_reset_count (resync),
		.i_recived_bip (recived_bip),
		.i_calculated_bip (calculated_bip),
		.o_rf_error_count (o_rf_error_counter)
	);

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen
#(
	parameter int PERIOD = 8
)
(
	output logic o_clock
);

	initial
	begin
		o_clock = 1'b0;
	end

	always
	begin
		#(PERIOD / 2) o_clock = ~o_clock; // half period per toggle
	end

endmodule

/* am_lock_asserts.sv */
module am_lock_asserts
(
	input logic i_clock,
	input logic i_reset,
	input logic i_rf_enable,
	input logic i_valid,
	input logic i_resync,
	input logic i_start_of_lane,
	input logic i_am_lock,
	input logic [am_lock_pkg::NB_LANE_ID-1:0] i_lane_id
);

	resync_single_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
		i_resync |=> !i_resync)
		else $error("o_resync was high for more than one cycle");

	start_needs_valid: assert property (@(posedge i_clock) disable iff (i_reset)
		i_start_of_lane |-> (i_valid && i_rf_enable))
		else $error("o_start_of_lane without a valid block");

	// lane id may only change together with the lock
	lane_id_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_am_lock && $past(i_am_lock)) |-> $stable(i_lane_id))
		else $error("o_lane_id changed while o_am_lock was high");

endmodule

bind am_lock_module am_lock_asserts u_am_lock_asserts
(
	.i_clock (i_clock),
	.i_reset (i_reset),
	.i_rf_enable (i_rf_enable),
	.i_valid (i_valid),
	.i_resync (o_resync),
	.i_start_of_lane (o_start_of_lane),
	.i_am_lock (o_am_lock),
	.i_lane_id (o_lane_id)
);

/* am_lock_tb.sv */
module am_lock_tb;

	import am_lock_pkg::*;

	localparam int N_BLOCKS = 15;
	localparam int NB_ERROR_COUNTER = 32;
	localparam int NB_INV_AM = 3;
	localparam int NB_VAL_AM = 5;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_VECTORS = 64;
	localparam int N_FIELDS = 11;
	localparam logic [31:0] SEED = 32'h52e2ab86;
	localparam logic [NB_AM-1:0] COMPARE_MASK = 48'hFFFFFF_00FFFF; // M4 not compared

	// field offsets inside one vector
	localparam int FLD_COUNT = 0;
	localparam int FLD_VALID = 1;
	localparam int FLD_BLOCK_LOCK = 2;
	localparam int FLD_INV_THR = 3;
	localparam int FLD_VAL_THR = 4;
	localparam int FLD_DATA = 5;
	localparam int FLD_EXP_DATA = 6;
	localparam int FLD_EXP_LOCK = 7;
	localparam int FLD_EXP_LANE = 8;
	localparam int FLD_EXP_RESYNC = 9;
	localparam int FLD_EXP_ERRORS = 10;

	logic clock;
	logic reset;
	logic rf_enable;
	logic valid;
	logic block_lock;
	logic [NB_DATA_CODED-1:0] data_in;
	logic [NB_INV_AM-1:0] invalid_am_thr;
	logic [NB_VAL_AM-1:0] valid_am_thr;
	logic [NB_AM-1:0] compare_mask;
	logic [NB_DATA_CODED-1:0] data_out;
	logic [NB_LANE_ID-1:0] lane_id;
	logic [NB_ERROR_COUNTER-1:0] error_counter;
	logic am_lock;
	logic resync;
	logic start_of_lane;

	logic [NB_DATA_CODED-1:0] patterns [MAX_VECTORS * N_FIELDS];
	int n_vectors;
	int n_blocks;
	int cycle_limit = 64;
	int cycle_count = 0;
	int checks_done = 0;
	logic tracking; // a lane marker was seen, period runs
	int since_marker; // valid blocks since the last marker position

	tb_clock_gen #(.PERIOD (8)) u_tb_clock_gen (.o_clock (clock));

	am_lock_module
	#(
		.N_BLOCKS (N_BLOCKS),
		.NB_ERROR_COUNTER (NB_ERROR_COUNTER),
		.NB_INV_AM (NB_INV_AM),
		.NB_VAL_AM (NB_VAL_AM)
	)
	u_am_lock_module
	(
		.i_clock (clock),
		.i_reset (reset),
		.i_rf_enable (rf_enable),
		.i_valid (valid),
		.i_block_lock (block_lock),
		.i_data (data_in),
		.i_rf_invalid_am_thr (invalid_am_thr),
		.i_rf_valid_am_thr (valid_am_thr),
		.i_rf_compare_mask (compare_mask),
		.o_data (data_out),
		.o_lane_id (lane_id),
		.o_rf_error_counter (error_counter),
		.o_am_lock (am_lock),
		.o_resync (resync),
		.o_start_of_lane (start_of_lane)
	);

	task automatic check_value(input string name, input logic [NB_DATA_CODED-1:0] actual,
		input logic [NB_DATA_CODED-1:0] expected);
		if (actual !== expected)
		begin
			$display("Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("tests failed");
			$fatal(1, "output mismatch");
		end
		checks_done++;
	endtask

	// block carries one of the lane markers in its compared bytes
	function automatic logic is_marker(input logic [NB_DATA_CODED-1:0] block);
		logic [NB_AM-1:0] field;
		logic found;
		field = {block[63:40], block[31:8]}; // M0-M2, M4-M6
		found = 1'b0;
		for (int lane = 0; lane < N_ALIGNER; lane++)
		begin
			if ((field & COMPARE_MASK) == (AM_TABLE[lane] & COMPARE_MASK))
			begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// follows the marker period over valid blocks
	task automatic update_period(input int base, input logic at_marker);
		if (patterns[base + FLD_EXP_RESYNC][0])
		begin
			tracking = 1'b0; // search restarts
		end
		else if (tracking)
		begin
			since_marker = at_marker ? 0 : since_marker + 1;
		end
		else if (patterns[base + FLD_BLOCK_LOCK][0] && is_marker(patterns[base + FLD_DATA]))
		begin
			tracking = 1'b1; // first sighting
			since_marker = 0;
		end
	endtask

	// registered outputs must already hold the values of the next valid block
	task automatic insert_gap(input int base);
		@(posedge clock);
		valid <= 1'b0;
		block_lock <= patterns[base + FLD_BLOCK_LOCK][0];
		data_in <= patterns[base + FLD_DATA];
		@(negedge clock);
		check_value("o_data in gap", data_out, data_in);
		check_value("o_resync in gap", NB_DATA_CODED'(resync), '0);
		check_value("o_start_of_lane in gap", NB_DATA_CODED'(start_of_lane), '0);
		check_value("o_am_lock in gap", NB_DATA_CODED'(am_lock), patterns[base + FLD_EXP_LOCK]);
		check_value("o_lane_id in gap", NB_DATA_CODED'(lane_id), patterns[base + FLD_EXP_LANE]);
		check_value("o_rf_error_counter in gap", NB_DATA_CODED'(error_counter),
			patterns[base + FLD_EXP_ERRORS]);
	endtask

	task automatic apply_vector(input int base);
		logic block_valid;
		logic exp_start;
		block_valid = patterns[base + FLD_VALID][0];
		exp_start = block_valid && tracking && (since_marker == N_BLOCKS);
		@(posedge clock);
		valid <= patterns[base + FLD_VALID][0];
		block_lock <= patterns[base + FLD_BLOCK_LOCK][0];
		invalid_am_thr <= patterns[base + FLD_INV_THR][NB_INV_AM-1:0];
		valid_am_thr <= patterns[base + FLD_VAL_THR][NB_VAL_AM-1:0];
		data_in <= patterns[base + FLD_DATA];
		@(negedge clock); // combinational outputs settled
		check_value("o_data", data_out, patterns[base + FLD_EXP_DATA]);
		check_value("o_am_lock", NB_DATA_CODED'(am_lock), patterns[base + FLD_EXP_LOCK]);
		check_value("o_lane_id", NB_DATA_CODED'(lane_id), patterns[base + FLD_EXP_LANE]);
		check_value("o_resync", NB_DATA_CODED'(resync), patterns[base + FLD_EXP_RESYNC]);
		check_value("o_start_of_lane", NB_DATA_CODED'(start_of_lane), NB_DATA_CODED'(exp_start));
		check_value("o_rf_error_counter", NB_DATA_CODED'(error_counter),
			patterns[base + FLD_EXP_ERRORS]);
		if (block_valid)
		begin
			update_period(base, exp_start);
		end
	endtask

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout: the run did not end within %0d cycles", cycle_limit);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		int base;
		int repeat_count;

		void'($urandom(SEED));
		reset = 1'b1;
		rf_enable = 1'b1;
		valid = 1'b0;
		block_lock = 1'b0;
		data_in = '0;
		invalid_am_thr = '0;
		valid_am_thr = '0;
		compare_mask = COMPARE_MASK;
		tracking = 1'b0;
		since_marker = 0;

		for (int i = 0; i < MAX_VECTORS * N_FIELDS; i++)
		begin
			patterns[i] = '0;
		end
		$readmemh("am_lock_patterns.txt", patterns);

		// a zero repeat count ends the list
		n_vectors = 0;
		n_blocks = 0;
		while (n_vectors < MAX_VECTORS && patterns[n_vectors * N_FIELDS + FLD_COUNT] != '0)
		begin
			n_blocks += int'(patterns[n_vectors * N_FIELDS + FLD_COUNT]);
			n_vectors++;
		end
		cycle_limit = 2 * n_blocks + 64; // worst case is one gap per block

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		for (int v = 0; v < n_vectors; v++)
		begin
			base = v * N_FIELDS;
			repeat_count = int'(patterns[base + FLD_COUNT]);
			for (int r = 0; r < repeat_count; r++)
			begin
				if ($urandom % 4 == 0)
				begin
					insert_gap(base);
				end
				apply_vector(base);
			end
		end

		@(posedge clock);
		if (checks_done > 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
		begin
			$display("no checks ran because the pattern file held no vectors");
			$display("tests failed");
			$fatal(1, "empty pattern file");
		end
	end

endmodule

/* am_lock_patterns.txt */
// count valid block_lock invalid_thr valid_thr i_data
// then expected: o_data o_am_lock o_lane_id o_resync o_rf_error_counter
// search, then three lane 7 markers 16 blocks apart
05 1 1 2 03 10123456789abcdef 10123456789abcdef 0 00 0 00000000
01 1 1 2 03 27b45661884ba99e7 27b45661884ba99e7 0 00 0 00000000
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 0 00 0 00000000
01 1 1 2 03 27b45661884ba99e7 27b45661884ba99e7 0 00 0 00000000
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 0 00 0 00000000
01 1 1 2 03 27b45661884ba99e7 27b45661884ba99e7 0 00 0 00000000
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000000
// locked, marker replaced by idle, a marker on a non-valid cycle passes
01 1 1 2 03 27b45661884ba99e7 21e00000000000000 1 07 0 00000000
07 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000000
01 0 1 2 03 27b45661884ba99e7 27b45661884ba99e7 1 07 0 00000000
08 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000000
// M4 corrupt is masked out, M5 corrupt is a bad marker, BIP7 keeps parity
01 1 1 2 03 27b45661885ba99e6 21e00000000000000 1 07 0 00000000
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000000
01 1 1 2 03 27b45661884bb99e6 21e00000000000000 1 07 0 00000000
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000000
01 1 1 2 03 27b45661884ba99e7 21e00000000000000 1 07 0 00000000
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000000
// one payload bit flipped, counted at the next marker
01 1 1 2 03 27b45661884ba99e7 21e00000000000000 1 07 0 00000000
07 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000000
01 1 1 2 03 10123456789abcdee 10123456789abcdee 1 07 0 00000000
07 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000000
01 1 1 2 03 27b45661884ba99e7 21e00000000000000 1 07 0 00000000
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000001
01 1 1 2 03 27b45661884ba99e7 21e00000000000000 1 07 0 00000001
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000001
// two bad markers in a row drop the lock
01 1 1 2 03 27b45661884bb99e6 21e00000000000000 1 07 0 00000001
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000001
01 1 1 2 03 27b45661884bb99e6 21e00000000000000 1 07 1 00000001
03 1 1 2 03 10123456789abcdef 10123456789abcdef 0 00 0 00000000
// relock with one parity error, then block lock lost
01 1 1 2 03 27b45661884ba99e7 27b45661884ba99e7 0 00 0 00000000
01 1 1 2 03 10123456789abcdee 10123456789abcdee 0 00 0 00000000
0e 1 1 2 03 10123456789abcdef 10123456789abcdef 0 00 0 00000000
01 1 1 2 03 27b45661884ba99e7 27b45661884ba99e7 0 00 0 00000000
0f 1 1 2 03 10123456789abcdef 10123456789abcdef 0 00 0 00000001
01 1 1 2 03 27b45661884ba99e7 27b45661884ba99e7 0 00 0 00000001
0a 1 1 2 03 10123456789abcdef 10123456789abcdef 1 07 0 00000001
01 1 0 2 03 10123456789abcdef 10123456789abcdef 1 07 1 00000001
02 1 0 2 03 10123456789abcdef 10123456789abcdef 0 00 0 00000000
01 1 0 2 03 27b45661884ba99e7 27b45661884ba99e7 0 00 0 00000000
02 1 1 2 03 10123456789abcdef 10123456789abcdef 0 00 0 00000000

/* sim.f */
am_lock_pkg.sv
am_lock_comparator.sv
am_lock_fsm.sv
bip_calculator.sv
am_error_counter.sv
am_lock_module.sv
tb_clock_gen.sv
am_lock_asserts.sv
am_lock_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module am_lock_tb -f sim.f -o am_lock_sim

./obj_dir/am_lock_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation PASSED"
